// File: logic/arith_pkg.sv
`default_nettype none

package arith_pkg;

  // Default operand width for every unit
  localparam int DATA_W = 32;

  // Opcodes seen at the request port
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLL  = 4'd5,
    OP_SRL  = 4'd6,
    OP_SRA  = 4'd7,
    OP_SLT  = 4'd8,  // Signed compare
    OP_MUL  = 4'd9,  // Low word of product
    OP_MULH = 4'd10, // Signed high word
    OP_DIV  = 4'd11,
    OP_REM  = 4'd12
  } alu_op_t;

  // Top level FSM
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_MUL  = 2'd1,
    ST_DIV  = 2'd2,
    ST_DONE = 2'd3
  } core_state_t;

endpackage

`default_nettype wire

// File: logic/alu_simple.sv
`timescale 1ns/1ns
`default_nettype none

module alu_simple #(
  parameter int WIDTH = arith_pkg::DATA_W
) (
  input  wire arith_pkg::alu_op_t op,
  input  wire logic [WIDTH-1:0]   a,
  input  wire logic [WIDTH-1:0]   b,
  output logic [WIDTH-1:0]        y
);

  localparam int SH_W = $clog2(WIDTH);

  logic [SH_W-1:0]  shamt;
  logic [WIDTH-1:0] sum;
  logic [WIDTH-1:0] diff;
  logic             less;

  assign shamt = b[SH_W-1:0];  // Only the low bits count
  assign sum   = a + b;
  assign diff  = a - b;
  assign less  = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      arith_pkg::OP_ADD: y = sum;
      arith_pkg::OP_SUB: y = diff;
      arith_pkg::OP_AND: y = a & b;
      arith_pkg::OP_OR:  y = a | b;
      arith_pkg::OP_XOR: y = a ^ b;
      arith_pkg::OP_SLL: y = a << shamt;
      arith_pkg::OP_SRL: y = a >> shamt;
      // Sign bit fills from the left
      arith_pkg::OP_SRA: y = $signed(a) >>> shamt;
      arith_pkg::OP_SLT: y = {{(WIDTH-1){1'b0}}, less};
      default:           y = '0;  // Multicycle ops go elsewhere
    endcase
  end

endmodule

`default_nettype wire

// File: logic/mul_seq.sv
`timescale 1ns/1ns
`default_nettype none

module mul_seq #(
  parameter int WIDTH = arith_pkg::DATA_W
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             start,
  input  wire logic             mul_high,
  input  wire logic [WIDTH-1:0] a,
  input  wire logic [WIDTH-1:0] b,
  output logic                  busy,
  output logic                  done,
  output logic [WIDTH-1:0]      p
);

  localparam int CNT_W = $clog2(WIDTH);

  typedef enum logic [1:0] {
    MUL_IDLE = 2'd0,
    MUL_RUN  = 2'd1,
    MUL_FIX  = 2'd2
  } mul_state_t;

  mul_state_t       state;
  logic [CNT_W-1:0] cnt;
  logic [2*WIDTH-1:0] mcand;   // Shifted multiplicand
  logic [2*WIDTH-1:0] acc;     // Running product magnitude
  logic [WIDTH-1:0]   mplier;
  logic               neg;
  logic               high_q;
  logic [WIDTH-1:0]   a_mag;
  logic [WIDTH-1:0]   b_mag;
  logic [2*WIDTH-1:0] prod;

  assign a_mag = a[WIDTH-1] ? -a : a;
  assign b_mag = b[WIDTH-1] ? -b : b;
  assign prod  = neg ? -acc : acc;  // Restore the sign
  assign busy  = (state != MUL_IDLE);

  // Control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= MUL_IDLE;
      cnt   <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        MUL_IDLE: if (start) begin
          state <= MUL_RUN;
          cnt   <= '0;
        end
        MUL_RUN: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(WIDTH - 1)) state <= MUL_FIX;
        end
        MUL_FIX: begin
          state <= MUL_IDLE;
          done  <= 1'b1;
        end
        default: state <= MUL_IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (state == MUL_IDLE && start) begin
      mcand  <= {{WIDTH{1'b0}}, a_mag};
      mplier <= b_mag;
      acc    <= '0;
      neg    <= a[WIDTH-1] ^ b[WIDTH-1];
      high_q <= mul_high;
    end else if (state == MUL_RUN) begin
      if (mplier[0]) acc <= acc + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end else if (state == MUL_FIX) begin
      p <= high_q ? prod[2*WIDTH-1:WIDTH] : prod[WIDTH-1:0];
    end
  end

endmodule

`default_nettype wire

// File: logic/div_seq.sv
`timescale 1ns/1ns
`default_nettype none

module div_seq #(
  parameter int WIDTH = arith_pkg::DATA_W
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             start,
  input  wire logic             want_rem,
  input  wire logic [WIDTH-1:0] dividend,
  input  wire logic [WIDTH-1:0] divisor,
  output logic                  busy,
  output logic                  done,
  output logic [WIDTH-1:0]      res
);

  localparam int CNT_W = $clog2(WIDTH);

  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_RUN  = 2'd1,
    DIV_FIX  = 2'd2
  } div_state_t;

  div_state_t         state;
  logic [CNT_W-1:0]   cnt;
  logic [WIDTH-1:0]   m;         // Divisor magnitude
  logic [2*WIDTH-1:0] combined;  // Partial remainder : quotient
  logic               subtract;
  logic               negative;
  logic               div_zero;
  logic               rem_q;
  logic [2*WIDTH-1:0] shifted;
  logic [WIDTH-1:0]   trial;
  logic [WIDTH-1:0]   rem_fix;
  logic [WIDTH-1:0]   quo_fix;

  assign busy = (state != DIV_IDLE);

  // One non-restoring step
  always_comb begin
    shifted = {combined[2*WIDTH-2:0], 1'b0};
    trial   = subtract ? shifted[2*WIDTH-1:WIDTH] - m
                       : shifted[2*WIDTH-1:WIDTH] + m;
  end

  // Final correction of remainder and quotient sign
  always_comb begin
    rem_fix = combined[2*WIDTH-1] ? combined[2*WIDTH-1:WIDTH] + m
                                  : combined[2*WIDTH-1:WIDTH];
    quo_fix = negative ? -combined[WIDTH-1:0] : combined[WIDTH-1:0];
    if (div_zero) begin
      rem_fix = '0;
      quo_fix = {1'b0, {(WIDTH-1){1'b1}}};  // Largest positive value
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= DIV_IDLE;
      cnt   <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        DIV_IDLE: if (start) begin
          state <= DIV_RUN;
          cnt   <= '0;
        end
        DIV_RUN: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(WIDTH - 1)) state <= DIV_FIX;
        end
        DIV_FIX: begin
          state <= DIV_IDLE;
          done  <= 1'b1;
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  // Operand prep, iterations and the fix-up write
  always_ff @(posedge clk) begin
    if (state == DIV_IDLE && start) begin
      m        <= divisor[WIDTH-1] ? -divisor : divisor;
      combined <= {{WIDTH{1'b0}}, dividend[WIDTH-1] ? -dividend : dividend};
      negative <= dividend[WIDTH-1] ^ divisor[WIDTH-1];
      subtract <= 1'b1;                 // Remainder starts at zero
      div_zero <= (divisor == '0);
      rem_q    <= want_rem;
    end else if (state == DIV_RUN) begin
      // Sign of the new remainder picks the next step and the quotient bit
      combined <= {trial, shifted[WIDTH-1:1], ~trial[WIDTH-1]};
      subtract <= ~trial[WIDTH-1];
    end else if (state == DIV_FIX) begin
      res <= rem_q ? rem_fix : quo_fix;
    end
  end

endmodule

`default_nettype wire

// File: logic/arith_core.sv
`timescale 1ns/1ns
`default_nettype none

module arith_core #(
  parameter int WIDTH = arith_pkg::DATA_W
) (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               in_valid,
  output logic                    in_ready,
  input  wire arith_pkg::alu_op_t op,
  input  wire logic [WIDTH-1:0]   a,
  input  wire logic [WIDTH-1:0]   b,
  output logic                    out_valid,
  input  wire logic               out_ready,
  output logic [WIDTH-1:0]        result
);

  arith_pkg::core_state_t state;

  logic             accept;
  logic             is_mul;
  logic             is_div;
  logic [WIDTH-1:0] alu_y;
  logic             mul_start;
  logic             mul_busy;
  logic             mul_done;
  logic [WIDTH-1:0] mul_p;
  logic             div_start;
  logic             div_busy;
  logic             div_done;
  logic [WIDTH-1:0] div_res;

  assign is_mul = (op == arith_pkg::OP_MUL) || (op == arith_pkg::OP_MULH);
  assign is_div = (op == arith_pkg::OP_DIV) || (op == arith_pkg::OP_REM);

  assign in_ready  = (state == arith_pkg::ST_IDLE);  // One request in flight
  assign out_valid = (state == arith_pkg::ST_DONE);
  assign accept    = in_valid && in_ready;

  assign mul_start = accept && is_mul;  // Same cycle as acceptance
  assign div_start = accept && is_div;

  alu_simple #(
    .WIDTH (WIDTH)
  ) alu_i (
    .op (op),
    .a  (a),
    .b  (b),
    .y  (alu_y)
  );

  mul_seq #(
    .WIDTH (WIDTH)
  ) mul_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (mul_start),
    .mul_high (op == arith_pkg::OP_MULH),
    .a        (a),
    .b        (b),
    .busy     (mul_busy),
    .done     (mul_done),
    .p        (mul_p)
  );

  div_seq #(
    .WIDTH (WIDTH)
  ) div_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (div_start),
    .want_rem (op == arith_pkg::OP_REM),
    .dividend (a),
    .divisor  (b),
    .busy     (div_busy),
    .done     (div_done),
    .res      (div_res)
  );

  // Dispatch FSM
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= arith_pkg::ST_IDLE;
    end else begin
      case (state)
        arith_pkg::ST_IDLE: begin
          if (accept) begin
            if (is_mul)      state <= arith_pkg::ST_MUL;
            else if (is_div) state <= arith_pkg::ST_DIV;
            else             state <= arith_pkg::ST_DONE;
          end
        end
        arith_pkg::ST_MUL: if (mul_done) state <= arith_pkg::ST_DONE;
        arith_pkg::ST_DIV: if (div_done) state <= arith_pkg::ST_DONE;
        arith_pkg::ST_DONE: begin
          if (out_ready) state <= arith_pkg::ST_IDLE;  // Result taken
        end
        default: state <= arith_pkg::ST_IDLE;
      endcase
    end
  end

  // Result holds while waiting on out_ready
  always_ff @(posedge clk) begin
    if (accept && !is_mul && !is_div) begin
      result <= alu_y;
    end else if (state == arith_pkg::ST_MUL && mul_done) begin
      result <= mul_p;
    end else if (state == arith_pkg::ST_DIV && div_done) begin
      result <= div_res;
    end
  end

endmodule

`default_nettype wire

// File: sim/arith_core_chk.sv
`timescale 1ns/1ns
`default_nettype none

module arith_core_chk #(
  parameter int WIDTH = arith_pkg::DATA_W
) (
  input wire logic             clk,
  input wire logic             rst_n,
  input wire logic             in_ready,
  input wire logic             out_valid,
  input wire logic             out_ready,
  input wire logic [WIDTH-1:0] result,
  input wire logic             mul_busy,
  input wire logic             div_busy
);

  ready_valid_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(in_ready && out_valid)
  ) else $error("in_ready and out_valid high in the same cycle");

  // Back-pressure keeps the held result steady
  result_held: assert property (
    @(posedge clk) disable iff (!rst_n) (out_valid && !out_ready) |=> $stable(result)
  ) else $error("result changed while waiting on out_ready");

  valid_low_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> !out_valid
  ) else $error("out_valid high in the first cycle after reset");

  // Both units have finished before a new request can be taken
  units_idle_when_ready: assert property (
    @(posedge clk) disable iff (!rst_n) in_ready |-> !(mul_busy || div_busy)
  ) else $error("a unit is still busy while the core is ready for a request");

endmodule

bind arith_core arith_core_chk #(
  .WIDTH (WIDTH)
) chk_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .result    (result),
  .mul_busy  (mul_busy),
  .div_busy  (div_busy)
);

`default_nettype wire

// File: sim/arith_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module arith_core_tb;

  localparam int W    = arith_pkg::DATA_W;
  localparam int SH_W = $clog2(W);

  localparam logic [W-1:0] MIN_VAL = {1'b1, {(W-1){1'b0}}};
  localparam logic [W-1:0] MAX_VAL = {1'b0, {(W-1){1'b1}}};

  localparam int N_SINGLE = 300;
  localparam int N_MUL    = 120;
  localparam int N_DIV    = 120;
  localparam int N_DZ     = 30;
  localparam int N_MIXED  = 200;
  localparam int N_EDGE   = 100;  // 5 x 5 corner operands for four opcodes
  localparam int N_OPS    = N_SINGLE + N_MUL + N_DIV + N_DZ + N_MIXED + N_EDGE;
  localparam int TIMEOUT_NS = N_OPS * (W + 3 + 10) * 10 + 20000;

  logic               clk;
  logic               rst_n;
  logic               in_valid;
  logic               in_ready;
  arith_pkg::alu_op_t op;
  logic [W-1:0]       a;
  logic [W-1:0]       b;
  logic               out_valid;
  logic               out_ready;
  logic [W-1:0]       result;

  logic               bp_mode;       // Random out_ready when set
  logic               timed;         // Latency of the pending result already checked
  int                 cycle_cnt;
  int                 accept_cycle;
  int                 checked;
  int                 mismatch_errors;
  int                 other_errors;
  logic [W-1:0]       exp_q[$];
  arith_pkg::alu_op_t op_q[$];

  arith_core #(
    .WIDTH (W)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .op        (op),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .result    (result)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // Expected result straight from the operation rules
  function automatic logic [W-1:0] model(input arith_pkg::alu_op_t o, input logic [W-1:0] x,
                                         input logic [W-1:0] y);
    logic [SH_W-1:0]  sh;
    logic [2*W-1:0]   ext;
    logic [2*W-1:0]   full;
    logic [W:0]       xm;
    logic [W:0]       ym;
    logic [W:0]       qm;
    logic [W:0]       rm;
    logic [W-1:0]     q;
    logic [W-1:0]     res;
    sh   = y[SH_W-1:0];
    ext  = {{W{x[W-1]}}, x} >> sh;  // Sign extended, so the top fills with the sign
    full = $signed({{W{x[W-1]}}, x}) * $signed({{W{y[W-1]}}, y});
    xm   = x[W-1] ? ({1'b0, ~x} + 1'b1) : {1'b0, x};
    ym   = y[W-1] ? ({1'b0, ~y} + 1'b1) : {1'b0, y};
    qm   = (y == '0) ? '0 : xm / ym;
    rm   = (y == '0) ? '0 : xm % ym;
    q    = qm[W-1:0];
    case (o)
      arith_pkg::OP_ADD:  res = x + y;
      arith_pkg::OP_SUB:  res = x - y;
      arith_pkg::OP_AND:  res = x & y;
      arith_pkg::OP_OR:   res = x | y;
      arith_pkg::OP_XOR:  res = x ^ y;
      arith_pkg::OP_SLL:  res = x << sh;
      arith_pkg::OP_SRL:  res = x >> sh;
      arith_pkg::OP_SRA:  res = ext[W-1:0];
      arith_pkg::OP_SLT:  res = ($signed(x) < $signed(y)) ? W'(1) : '0;
      arith_pkg::OP_MUL:  res = full[W-1:0];
      arith_pkg::OP_MULH: res = full[2*W-1:W];
      arith_pkg::OP_DIV: begin
        if (y == '0) res = MAX_VAL;
        else         res = (x[W-1] != y[W-1]) ? (~q + 1'b1) : q;  // Truncates and wraps
      end
      arith_pkg::OP_REM:  res = rm[W-1:0];  // Magnitude remainder
      default:            res = '0;
    endcase
    return res;
  endfunction

  function automatic logic is_multi(input arith_pkg::alu_op_t o);
    return o == arith_pkg::OP_MUL || o == arith_pkg::OP_MULH ||
           o == arith_pkg::OP_DIV || o == arith_pkg::OP_REM;
  endfunction

  function automatic logic [W-1:0] edge_value(input int i);
    case (i)
      0:       return MIN_VAL;
      1:       return MAX_VAL;
      2:       return '1;  // -1
      3:       return W'(1);
      default: return '0;
    endcase
  endfunction

  // Mostly random, with corner values mixed in
  function automatic logic [W-1:0] pick_operand();
    logic [63:0] raw;
    int          sel;
    raw = {$urandom(), $urandom()};
    sel = $urandom_range(15);
    if (sel < 5) return edge_value(sel);
    return raw[W-1:0];
  endfunction

  function automatic arith_pkg::alu_op_t op_in_range(input int lo, input int hi);
    logic [3:0] code;
    code = 4'($urandom_range(hi, lo));
    return arith_pkg::alu_op_t'(code);
  endfunction

  // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic send_request(input arith_pkg::alu_op_t o, input logic [W-1:0] x,
                              input logic [W-1:0] y);
    in_valid = 1'b1;
    op       = o;
    a        = x;
    b        = y;
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    a        = pick_operand();  // Don't care once accepted
    b        = pick_operand();
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_random_ops(input int n, input int lo, input int hi);
    repeat (n) begin
      send_request(op_in_range(lo, hi), pick_operand(), pick_operand());
      idle_cycles($urandom_range(2));
    end
  endtask

  task automatic run_edge_ops(input arith_pkg::alu_op_t o);
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) send_request(o, edge_value(i), edge_value(j));
    end
  endtask

  task automatic run_div_zero(input int n);
    repeat (n) begin
      send_request(op_in_range(11, 12), pick_operand(), '0);
      idle_cycles($urandom_range(2));
    end
  endtask

  task automatic check_latency();
    int lat;
    int want;
    timed = 1'b1;
    if (op_q.size() != 0) begin
      lat  = cycle_cnt - accept_cycle;
      want = is_multi(op_q[0]) ? W + 3 : 1;
      assert (lat == want) else begin
        $display("MISMATCH at %0t ns: %s latency expected %0d cycles, got %0d",
                 $time, op_q[0].name(), want, lat);
        mismatch_errors++;
      end
    end
  endtask

  task automatic take_result();
    logic [W-1:0]       want;
    arith_pkg::alu_op_t o;
    if (exp_q.size() == 0) begin
      $display("Result handed out at %0t ns with no request pending", $time);
      other_errors++;
    end else begin
      want = exp_q.pop_front();
      o    = op_q.pop_front();
      checked++;
      assert (result === want) else begin
        $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, o.name(), want, result);
        mismatch_errors++;
      end
    end
  endtask

  task automatic drain_results();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 2 * (W + 3) + 20) begin
      @(posedge clk);
      waited++;
    end
    assert (exp_q.size() == 0) else begin
      $display("Run ended with %0d accepted requests never answered", exp_q.size());
      other_errors++;
    end
  endtask

  task automatic finish_run();
    int total;
    total = mismatch_errors + other_errors;
    $display("Checked %0d results, %0d errors (%0d mismatches, %0d other)",
             checked, total, mismatch_errors, other_errors);
    if (total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  // Sampled mid-cycle, where handshakes for the next edge are settled
  always @(negedge clk) begin
    if (rst_n) begin
      assert (!(in_ready && exp_q.size() != 0)) else begin
        $display("in_ready high at %0t ns while a result was still held", $time);
        other_errors++;
      end
      if (out_valid && !timed) check_latency();
      if (out_valid && out_ready) take_result();
      if (in_valid && in_ready) begin
        exp_q.push_back(model(op, a, b));
        op_q.push_back(op);
        accept_cycle = cycle_cnt;
        timed        = 1'b0;
      end
    end
  end

  initial begin : ready_driver
    int hold;
    hold = 0;
    forever begin
      @(posedge clk);
      #1;
      if (!bp_mode) begin
        out_ready = 1'b1;
      end else if (hold > 0) begin
        hold--;                           // Keep the level for a few cycles
      end else begin
        out_ready = ($urandom_range(9) < 5);
        hold      = $urandom_range(4);
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, the run did not complete", TIMEOUT_NS);
    other_errors++;
    finish_run();
  end

  initial begin : stimulus
    void'($urandom(71679));
    accept_cycle    = 0;
    checked         = 0;
    mismatch_errors = 0;
    other_errors    = 0;
    timed           = 1'b1;
    bp_mode         = 1'b0;
    rst_n           = 1'b0;
    in_valid        = 1'b0;
    op              = arith_pkg::OP_ADD;
    a               = '0;
    b               = '0;
    out_ready       = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    run_random_ops(N_SINGLE, 0, 8);       // Single-cycle opcodes
    run_edge_ops(arith_pkg::OP_MUL);
    run_edge_ops(arith_pkg::OP_MULH);
    run_random_ops(N_MUL, 9, 10);
    run_edge_ops(arith_pkg::OP_DIV);      // Includes MIN / -1 and x / 0
    run_edge_ops(arith_pkg::OP_REM);
    run_random_ops(N_DIV, 11, 12);
    run_div_zero(N_DZ);
    bp_mode = 1'b1;
    run_random_ops(N_MIXED, 0, 12);       // All opcodes under back-pressure
    drain_results();
    finish_run();
  end

endmodule

`default_nettype wire

// File: sim.f
logic/arith_pkg.sv
logic/alu_simple.sv
logic/mul_seq.sv
logic/div_seq.sv
logic/arith_core.sv
sim/arith_core_chk.sv
sim/arith_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the arith_core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module arith_core_tb -f sim.f -o arith_core_sim

status=0
output=$(./obj_dir/arith_core_sim 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx 'all tests passed'; then
  echo "Simulation result: PASS"
  exit 0
else
  echo "Simulation result: FAIL"
  exit 1
fi
